//--- design/eth_dispatch.sv
// Routes each packet by its head beat: data[47:0] is the destination MAC,
// data[63:48] the destination UDP port. The IP address is not checked

`timescale 1ns/1ps

module eth_dispatch
   import eth_switch_pkg::*;
(
   input  logic        i_reg_clk,
   input  logic        i_reset,
   input  axis_beat_t  i_in,
   input  logic        i_in_valid,
   output logic        o_in_ready,
   input  logic [47:0] i_my_mac,
   input  logic [15:0] i_udp_port0,
   input  logic [15:0] i_udp_port1,
   output axis_beat_t  o_vita,
   output logic        o_vita_valid,
   input  logic        i_vita_ready,
   output axis_beat_t  o_cpu,
   output logic        o_cpu_valid,
   input  logic        i_cpu_ready
);

   disp_state_e state;
   dest_e       head_dest;
   dest_e       dest_q;
   axis_beat_t  head_q;
   logic        head_pend;
   axis_beat_t  out_beat;
   logic        out_valid;
   logic        dest_ready;
   logic        out_xfer;

   // Classify the beat at the input
   always_comb begin
      if (i_in.data[47:0] != i_my_mac)
         head_dest = DEST_DROP;
      else if (i_in.data[63:48] == i_udp_port0 || i_in.data[63:48] == i_udp_port1)
         head_dest = DEST_VITA;
      else
         head_dest = DEST_CPU;
   end

   assign dest_ready = (dest_q == DEST_VITA) ? i_vita_ready : i_cpu_ready;

   // ----------------------------------------
   // Output select
   // ----------------------------------------
   always_comb begin
      out_beat   = i_in;
      out_valid  = 1'b0;
      o_in_ready = 1'b0;
      case (state)
         DISP_HEAD: o_in_ready = 1'b1;
         DISP_PASS: begin
            if (head_pend) begin
               out_beat  = head_q;
               out_valid = 1'b1;
            end else begin
               out_valid  = i_in_valid;
               o_in_ready = dest_ready;
            end
         end
         default:   o_in_ready = 1'b1;
      endcase
   end

   assign out_xfer     = out_valid & dest_ready;
   assign o_vita       = out_beat;
   assign o_cpu        = out_beat;
   assign o_vita_valid = out_valid & (dest_q == DEST_VITA);
   assign o_cpu_valid  = out_valid & (dest_q == DEST_CPU);

   // ----------------------------------------
   // FSM
   // ----------------------------------------
   always_ff @(posedge i_reg_clk) begin
      if (i_reset) begin
         state     <= DISP_HEAD;
         dest_q    <= DEST_DROP;
         head_pend <= 1'b0;
      end else begin
         case (state)
            DISP_HEAD: begin
               if (i_in_valid) begin
                  dest_q <= head_dest;
                  if (head_dest == DEST_DROP) begin
                     state <= i_in.last ? DISP_HEAD : DISP_DROP;
                  end else begin
                     head_pend <= 1'b1;
                     state     <= DISP_PASS;
                  end
               end
            end
            DISP_PASS: begin
               if (out_xfer) begin
                  head_pend <= 1'b0;
                  if (out_beat.last)
                     state <= DISP_HEAD;
               end
            end
            default: begin
               // Swallow the rest of a dropped packet
               if (i_in_valid && i_in.last)
                  state <= DISP_HEAD;
            end
         endcase
      end
   end

   always_ff @(posedge i_reg_clk) begin
      if (state == DISP_HEAD && i_in_valid)
         head_q <= i_in;
   end

endmodule

//--- design/eth_pkt_gate.sv
// Store-and-forward gate, a packet is released only after its last beat
// The error flag is sampled on the last beat; bad packets are discarded
// A packet longer than the buffer depth stalls the input forever

`timescale 1ns/1ps
`include "eth_switch_defines.svh"

module eth_pkt_gate
   import eth_switch_pkg::*;
(
   input  logic       i_reg_clk,
   input  logic       i_reset,
   input  axis_beat_t i_in,
   input  logic       i_in_valid,
   output logic       o_in_ready,
   output axis_beat_t o_out,
   output logic       o_out_valid,
   input  logic       i_out_ready
);

   localparam int AW    = `ETH_GATE_DEPTH_LOG2;
   localparam int DEPTH = 1 << AW;

   axis_beat_t  ram [DEPTH];

   // Pointers carry one extra wrap bit
   logic [AW:0] wr_ptr;
   logic [AW:0] commit_ptr;
   logic [AW:0] rd_ptr;
   logic [AW:0] used;
   logic        wr_en;
   logic        rd_en;

   // Occupancy counts uncommitted beats too
   assign used       = wr_ptr - rd_ptr;
   assign o_in_ready = ~used[AW];
   assign wr_en      = i_in_valid & o_in_ready;

   // ----------------------------------------
   // Write side
   // ----------------------------------------
   always_ff @(posedge i_reg_clk) begin
      if (wr_en)
         ram[wr_ptr[AW-1:0]] <= i_in;
   end

   always_ff @(posedge i_reg_clk) begin
      if (i_reset) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
      end else if (wr_en) begin
         if (!i_in.last) begin
            wr_ptr <= wr_ptr + 1'b1;
         end else if (i_in.user[3]) begin
            // Rewind over the whole bad packet
            wr_ptr <= commit_ptr;
         end else begin
            wr_ptr     <= wr_ptr + 1'b1;
            commit_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   // ----------------------------------------
   // Read side, one output register
   // ----------------------------------------
   assign rd_en = (rd_ptr != commit_ptr) & (~o_out_valid | i_out_ready);

   always_ff @(posedge i_reg_clk) begin
      if (i_reset) begin
         rd_ptr      <= '0;
         o_out_valid <= 1'b0;
      end else if (rd_en) begin
         rd_ptr      <= rd_ptr + 1'b1;
         o_out_valid <= 1'b1;
      end else if (i_out_ready) begin
         o_out_valid <= 1'b0;
      end
   end

   always_ff @(posedge i_reg_clk) begin
      if (rd_en)
         o_out <= ram[rd_ptr[AW-1:0]];
   end

endmodule

//--- design/eth_switch.sv
// Ethernet switch core on one clock; receive is gated then dispatched,
// transmit merges the VITA and CPU streams packet by packet

`timescale 1ns/1ps

module eth_switch
   import eth_switch_pkg::*;
(
   input  logic        i_reg_clk,
   input  logic        i_reset,
   input  reg_wr_t     i_wr,
   input  reg_rd_req_t i_rd,
   output logic        o_reg_rd_resp,
   output logic [31:0] o_reg_rd_data,
   input  axis_beat_t  i_eth_rx,
   input  logic        i_eth_rx_valid,
   output logic        o_eth_rx_ready,
   output axis_beat_t  o_e2v,
   output logic        o_e2v_valid,
   input  logic        i_e2v_ready,
   output axis_beat_t  o_e2c,
   output logic        o_e2c_valid,
   input  logic        i_e2c_ready,
   input  axis_beat_t  i_v2e,
   input  logic        i_v2e_valid,
   output logic        o_v2e_ready,
   input  axis_beat_t  i_c2e,
   input  logic        i_c2e_valid,
   output logic        o_c2e_ready,
   output axis_beat_t  o_eth_tx,
   output logic        o_eth_tx_valid,
   input  logic        i_eth_tx_ready
);

   logic [47:0] my_mac;
   logic [15:0] udp_port0;
   logic [15:0] udp_port1;
   axis_beat_t  gate_beat;
   logic        gate_valid;
   logic        gate_ready;

   eth_switch_regs regs0 (
      .i_reg_clk (i_reg_clk), .i_reset (i_reset), .i_wr (i_wr), .i_rd (i_rd),
      .o_reg_rd_resp (o_reg_rd_resp), .o_reg_rd_data (o_reg_rd_data),
      .o_my_mac (my_mac), .o_my_ip (), .o_udp_port0 (udp_port0), .o_udp_port1 (udp_port1));

   // ----------------------------------------
   // Receive path
   // ----------------------------------------
   eth_pkt_gate gate0 (
      .i_reg_clk (i_reg_clk), .i_reset (i_reset),
      .i_in (i_eth_rx), .i_in_valid (i_eth_rx_valid), .o_in_ready (o_eth_rx_ready),
      .o_out (gate_beat), .o_out_valid (gate_valid), .i_out_ready (gate_ready));

   eth_dispatch disp0 (
      .i_reg_clk (i_reg_clk), .i_reset (i_reset),
      .i_in (gate_beat), .i_in_valid (gate_valid), .o_in_ready (gate_ready),
      .i_my_mac (my_mac), .i_udp_port0 (udp_port0), .i_udp_port1 (udp_port1),
      .o_vita (o_e2v), .o_vita_valid (o_e2v_valid), .i_vita_ready (i_e2v_ready),
      .o_cpu (o_e2c), .o_cpu_valid (o_e2c_valid), .i_cpu_ready (i_e2c_ready));

   // Transmit path
   eth_tx_arbiter arb0 (
      .i_reg_clk (i_reg_clk), .i_reset (i_reset),
      .i_vita (i_v2e), .i_vita_valid (i_v2e_valid), .o_vita_ready (o_v2e_ready),
      .i_cpu (i_c2e), .i_cpu_valid (i_c2e_valid), .o_cpu_ready (o_c2e_ready),
      .o_out (o_eth_tx), .o_out_valid (o_eth_tx_valid), .i_out_ready (i_eth_tx_ready));

endmodule

//--- design/eth_switch_pkg.sv
// Shared stream and register bus types for the Ethernet switch
// Beat user bit 3 is the receive error flag from the MAC

`include "eth_switch_defines.svh"

package eth_switch_pkg;

   // One 64-bit stream beat
   typedef struct packed {
      logic [63:0] data;
      logic [3:0]  user;
      logic        last;
   } axis_beat_t;

   // Single-cycle register write strobe
   typedef struct packed {
      logic                       req;
      logic [`ETH_REG_AWIDTH-1:0] addr;
      logic [31:0]                data;
   } reg_wr_t;

   // Register read request, response comes one cycle later
   typedef struct packed {
      logic                       req;
      logic [`ETH_REG_AWIDTH-1:0] addr;
   } reg_rd_req_t;

   typedef enum logic [1:0] {DEST_VITA, DEST_CPU, DEST_DROP} dest_e;

   typedef enum logic [1:0] {DISP_HEAD, DISP_PASS, DISP_DROP} disp_state_e;

   typedef enum logic [1:0] {ARB_IDLE, ARB_VITA, ARB_CPU} arb_state_e;

endpackage

//--- design/eth_switch_regs.sv
// Switch configuration registers: MAC, IP and the two UDP ports
// Writes to unmapped addresses are ignored, reads of them get no response

`timescale 1ns/1ps
`include "eth_switch_defines.svh"

module eth_switch_regs
   import eth_switch_pkg::*;
(
   input  logic        i_reg_clk,
   input  logic        i_reset,
   input  reg_wr_t     i_wr,
   input  reg_rd_req_t i_rd,
   output logic        o_reg_rd_resp,
   output logic [31:0] o_reg_rd_data,
   output logic [47:0] o_my_mac,
   output logic [31:0] o_my_ip,
   output logic [15:0] o_udp_port0,
   output logic [15:0] o_udp_port1
);

   // ----------------------------------------
   // Write decode
   // ----------------------------------------
   always_ff @(posedge i_reg_clk) begin
      if (i_reset) begin
         o_my_mac                   <= `ETH_DEFAULT_MAC;
         o_my_ip                    <= `ETH_DEFAULT_IP;
         {o_udp_port1, o_udp_port0} <= `ETH_DEFAULT_UDP;
      end else if (i_wr.req) begin
         case (i_wr.addr)
            `ETH_REG_MAC_LSB: o_my_mac[31:0]             <= i_wr.data;
            // Only the top two MAC octets live here
            `ETH_REG_MAC_MSB: o_my_mac[47:32]            <= i_wr.data[15:0];
            `ETH_REG_IP:      o_my_ip                    <= i_wr.data;
            `ETH_REG_UDP:     {o_udp_port1, o_udp_port0} <= i_wr.data;
            default: ;
         endcase
      end
   end

   // ----------------------------------------
   // Read response, one cycle after request
   // ----------------------------------------
   always_ff @(posedge i_reg_clk) begin
      if (i_reset) begin
         o_reg_rd_resp <= 1'b0;
      end else begin
         o_reg_rd_resp <= 1'b0;
         if (i_rd.req) begin
            case (i_rd.addr)
               `ETH_REG_MAC_LSB,
               `ETH_REG_MAC_MSB,
               `ETH_REG_IP,
               `ETH_REG_UDP: o_reg_rd_resp <= 1'b1;
               default:      o_reg_rd_resp <= 1'b0;
            endcase
         end
      end
   end

   // Read data only matters while the response is high
   always_ff @(posedge i_reg_clk) begin
      if (i_rd.req) begin
         case (i_rd.addr)
            `ETH_REG_MAC_LSB: o_reg_rd_data <= o_my_mac[31:0];
            `ETH_REG_MAC_MSB: o_reg_rd_data <= {16'b0, o_my_mac[47:32]};
            `ETH_REG_IP:      o_reg_rd_data <= o_my_ip;
            `ETH_REG_UDP:     o_reg_rd_data <= {o_udp_port1, o_udp_port0};
            default:          o_reg_rd_data <= 32'b0;
         endcase
      end
   end

endmodule

//--- design/eth_tx_arbiter.sv
// Two-input packet merge, whole packets only, alternating when both wait
// One idle cycle is spent between packets to settle the grant

`timescale 1ns/1ps

module eth_tx_arbiter
   import eth_switch_pkg::*;
(
   input  logic       i_reg_clk,
   input  logic       i_reset,
   input  axis_beat_t i_vita,
   input  logic       i_vita_valid,
   output logic       o_vita_ready,
   input  axis_beat_t i_cpu,
   input  logic       i_cpu_valid,
   output logic       o_cpu_ready,
   output axis_beat_t o_out,
   output logic       o_out_valid,
   input  logic       i_out_ready
);

   arb_state_e state;
   logic       last_cpu;
   logic       pick_cpu;

   // CPU wins if alone, or if VITA had the last turn
   assign pick_cpu = i_cpu_valid & (~i_vita_valid | ~last_cpu);

   always_ff @(posedge i_reg_clk) begin
      if (i_reset) begin
         state    <= ARB_IDLE;
         last_cpu <= 1'b0;
      end else begin
         case (state)
            ARB_IDLE: begin
               if (i_vita_valid | i_cpu_valid) begin
                  state    <= pick_cpu ? ARB_CPU : ARB_VITA;
                  last_cpu <= pick_cpu;
               end
            end
            ARB_VITA: if (i_vita_valid & i_out_ready & i_vita.last) state <= ARB_IDLE;
            ARB_CPU:  if (i_cpu_valid & i_out_ready & i_cpu.last) state <= ARB_IDLE;
            default:  state <= ARB_IDLE;
         endcase
      end
   end

   // ----------------------------------------
   // Granted path passes straight through
   // ----------------------------------------
   always_comb begin
      o_out        = (state == ARB_CPU) ? i_cpu : i_vita;
      o_out_valid  = 1'b0;
      o_vita_ready = 1'b0;
      o_cpu_ready  = 1'b0;
      if (state == ARB_VITA) begin
         o_out_valid  = i_vita_valid;
         o_vita_ready = i_out_ready;
      end else if (state == ARB_CPU) begin
         o_out_valid = i_cpu_valid;
         o_cpu_ready = i_out_ready;
      end
   end

endmodule

//--- dv/eth_switch_tb.sv
// Testbench for the switch core; every output is checked beat by beat as it leaves
// Packets run twice, first with all outputs ready, then with random back-pressure
// New MAC and ports are written before any packet, the table assumes those values

`timescale 1ns/1ps
`include "eth_switch_defines.svh"

module eth_switch_tb
   import eth_switch_pkg::*;
();

   localparam logic [47:0] MY_MAC      = 48'h0211_2233_4455;
   localparam logic [47:0] FOREIGN_MAC = 48'h0211_2233_4456;
   localparam logic [15:0] PORT0       = 16'd5000;
   localparam logic [15:0] PORT1       = 16'd5001;
   localparam int          NPKT        = 12;
   localparam int          NTX         = 6;

   typedef struct packed {
      logic [7:0]  len;
      logic [47:0] mac;
      logic [15:0] port;
      logic        err;
      dest_e       dest;
   } pkt_entry_t;

   logic        reg_clk;
   logic        reset;
   reg_wr_t     wr;
   reg_rd_req_t rd;
   logic        rd_resp;
   logic [31:0] rd_data;
   axis_beat_t  eth_rx;
   axis_beat_t  e2v;
   axis_beat_t  e2c;
   axis_beat_t  v2e;
   axis_beat_t  c2e;
   axis_beat_t  eth_tx;
   logic        eth_rx_valid, eth_rx_ready;
   logic        e2v_valid, e2v_ready;
   logic        e2c_valid, e2c_ready;
   logic        v2e_valid, v2e_ready;
   logic        c2e_valid, c2e_ready;
   logic        eth_tx_valid, eth_tx_ready;

   pkt_entry_t  pkt_tbl [NPKT];
   int          tx_len [NTX] = '{3, 1, 5, 2, 4, 6};
   axis_beat_t  vita_q [$];
   axis_beat_t  cpu_q [$];
   axis_beat_t  txv_q [$];
   axis_beat_t  txc_q [$];
   integer      seed = 32'he944;
   int          cycles;
   int          limit;
   int          tx_sent;
   int          tx_seen;
   logic        bp_on;

   // Register map: byte offsets, reset values, values written, expected read back
   logic [`ETH_REG_AWIDTH-1:0] reg_addr [4] = '{`ETH_REG_MAC_LSB, `ETH_REG_MAC_MSB,
                                                `ETH_REG_IP, `ETH_REG_UDP};
   string       reg_name [4] = '{"mac_lsb", "mac_msb", "ip", "udp"};
   logic [31:0] reg_dflt [4] = '{32'h2f16c52f, 32'h00000080, 32'hc0a80a02, 32'hc002c001};
   logic [31:0] reg_new  [4] = '{32'h22334455, 32'hffff0211, 32'h0a000001, 32'h13891388};
   logic [31:0] reg_back [4] = '{32'h22334455, 32'h00000211, 32'h0a000001, 32'h13891388};

   eth_switch dut0 (
      .i_reg_clk (reg_clk), .i_reset (reset), .i_wr (wr), .i_rd (rd),
      .o_reg_rd_resp (rd_resp), .o_reg_rd_data (rd_data),
      .i_eth_rx (eth_rx), .i_eth_rx_valid (eth_rx_valid), .o_eth_rx_ready (eth_rx_ready),
      .o_e2v (e2v), .o_e2v_valid (e2v_valid), .i_e2v_ready (e2v_ready),
      .o_e2c (e2c), .o_e2c_valid (e2c_valid), .i_e2c_ready (e2c_ready),
      .i_v2e (v2e), .i_v2e_valid (v2e_valid), .o_v2e_ready (v2e_ready),
      .i_c2e (c2e), .i_c2e_valid (c2e_valid), .o_c2e_ready (c2e_ready),
      .o_eth_tx (eth_tx), .o_eth_tx_valid (eth_tx_valid), .i_eth_tx_ready (eth_tx_ready));

   initial begin
      reg_clk = 1'b0;
      forever #4 reg_clk = ~reg_clk;
   end

   // ----------------------------------------
   // Compare and failure helpers
   // ----------------------------------------
   task automatic stop_run(input string msg);
      $display("%0t: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1, "Run stopped at first failure");
   endtask

   task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
      if (got !== exp) begin
         $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Beat mismatch");
      end
   endtask

   task automatic check_rd_data(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Read data mismatch");
      end
   endtask

   function automatic int count_pending();
      return vita_q.size() + cpu_q.size() + txv_q.size() + txc_q.size();
   endfunction

   // ----------------------------------------
   // Register access, called 1 ns after an edge
   // ----------------------------------------
   task automatic reg_write(input logic [`ETH_REG_AWIDTH-1:0] addr, input logic [31:0] data);
      wr.req  = 1'b1;
      wr.addr = addr;
      wr.data = data;
      @(posedge reg_clk);
      #1;
      wr.req = 1'b0;
   endtask

   task automatic reg_read(input string name, input logic [`ETH_REG_AWIDTH-1:0] addr,
                           input logic [31:0] exp);
      rd.req  = 1'b1;
      rd.addr = addr;
      @(posedge reg_clk);
      #1;
      rd.req = 1'b0;
      if (!rd_resp)
         stop_run($sformatf("No read response for register %s", name));
      else
         check_rd_data({"o_reg_rd_data/", name}, rd_data, exp);
   endtask

   // Head beat is {port, mac}, later beats carry packet and beat numbers
   task automatic send_rx_pkt(input int idx);
      pkt_entry_t e;
      axis_beat_t beats [$];
      axis_beat_t b;
      e = pkt_tbl[idx];
      for (int i = 0; i < e.len; i++) begin
         b.data = (i == 0) ? {e.port, e.mac} : {8'(idx), 8'(i), 16'h0, 32'($random(seed))};
         b.user = {1'b0, 3'(i)};
         b.last = (i == e.len - 1);
         if (b.last)
            b.user[3] = e.err;
         beats.push_back(b);
      end
      foreach (beats[k]) begin
         if (!e.err && e.dest == DEST_VITA)
            vita_q.push_back(beats[k]);
         else if (!e.err && e.dest == DEST_CPU)
            cpu_q.push_back(beats[k]);
      end
      foreach (beats[k]) begin
         eth_rx       = beats[k];
         eth_rx_valid = 1'b1;
         #5;
         while (!eth_rx_ready) begin
            @(posedge reg_clk);
            #6;
         end
         @(posedge reg_clk);
         #1;
      end
      eth_rx_valid = 1'b0;
   endtask

   // Data bit 63 tags the source so the monitor can follow each stream
   task automatic send_tx_pkts(input logic src_cpu);
      axis_beat_t b;
      for (int p = 0; p < NTX; p++) begin
         for (int i = 0; i < tx_len[p]; i++) begin
            b.data = {src_cpu, 7'(p), 8'(i), 16'h0, 32'($random(seed))};
            b.user = 4'(i);
            b.last = (i == tx_len[p] - 1);
            tx_sent++;
            if (src_cpu) begin
               txc_q.push_back(b);
               c2e       = b;
               c2e_valid = 1'b1;
            end else begin
               txv_q.push_back(b);
               v2e       = b;
               v2e_valid = 1'b1;
            end
            #5;
            while (!(src_cpu ? c2e_ready : v2e_ready)) begin
               @(posedge reg_clk);
               #6;
            end
            @(posedge reg_clk);
            #1;
         end
      end
      if (src_cpu)
         c2e_valid = 1'b0;
      else
         v2e_valid = 1'b0;
   endtask

   // ----------------------------------------
   // Output ready, monitors and watchdog
   // ----------------------------------------
   initial begin
      logic [31:0] r;
      e2v_ready    = 1'b1;
      e2c_ready    = 1'b1;
      eth_tx_ready = 1'b1;
      forever begin
         @(posedge reg_clk);
         #1;
         r = $random(seed);
         e2v_ready    = !bp_on || (r[1:0] != 2'b00);
         e2c_ready    = !bp_on || (r[3:2] != 2'b00);
         eth_tx_ready = !bp_on || (r[5:4] != 2'b00);
      end
   end

   // Sampled late in the cycle, a beat seen here transfers on the next edge
   initial begin
      logic in_tx_pkt;
      logic tx_src_cpu;
      in_tx_pkt  = 1'b0;
      tx_src_cpu = 1'b0;
      tx_seen    = 0;
      forever begin
         @(posedge reg_clk);
         #6;
         if (e2v_valid && e2v_ready) begin
            if (vita_q.size() == 0)
               stop_run("Unexpected beat on the VITA output");
            else
               check_beat("o_e2v", e2v, vita_q.pop_front());
         end
         if (e2c_valid && e2c_ready) begin
            if (cpu_q.size() == 0)
               stop_run("Unexpected beat on the CPU output");
            else
               check_beat("o_e2c", e2c, cpu_q.pop_front());
         end
         if (eth_tx_valid && eth_tx_ready) begin
            // Source is fixed at the packet start, a foreign beat inside fails the compare
            if (!in_tx_pkt)
               tx_src_cpu = eth_tx.data[63];
            in_tx_pkt = !eth_tx.last;
            tx_seen++;
            if (tx_src_cpu && txc_q.size() != 0)
               check_beat("o_eth_tx", eth_tx, txc_q.pop_front());
            else if (!tx_src_cpu && txv_q.size() != 0)
               check_beat("o_eth_tx", eth_tx, txv_q.pop_front());
            else
               stop_run("Unexpected beat on the Ethernet transmit output");
         end
      end
   end

   initial begin
      cycles = 0;
      forever begin
         @(posedge reg_clk);
         cycles++;
         if (cycles > limit) begin
            $display("%0t: Timeout after %0d cycles with %0d beats still expected",
                     $time, cycles, count_pending());
            $display("TEST FAILED");
            $fatal(1, "Run stopped by the watchdog");
         end
      end
   end

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      int total;
      reset        = 1'b1;
      wr           = '0;
      rd           = '0;
      eth_rx       = '0;
      eth_rx_valid = 1'b0;
      v2e          = '0;
      v2e_valid    = 1'b0;
      c2e          = '0;
      c2e_valid    = 1'b0;
      bp_on        = 1'b0;
      tx_sent      = 0;

      // Destination follows the dispatch rule for MY_MAC and PORT0/PORT1
      pkt_tbl[0]  = '{8'd4, MY_MAC,      PORT0,  1'b0, DEST_VITA};
      pkt_tbl[1]  = '{8'd1, MY_MAC,      PORT1,  1'b0, DEST_VITA};
      pkt_tbl[2]  = '{8'd6, MY_MAC,      16'd80, 1'b0, DEST_CPU};
      pkt_tbl[3]  = '{8'd3, FOREIGN_MAC, PORT0,  1'b0, DEST_DROP};
      pkt_tbl[4]  = '{8'd5, MY_MAC,      PORT0,  1'b1, DEST_VITA};
      pkt_tbl[5]  = '{8'd2, MY_MAC,      PORT1,  1'b0, DEST_VITA};
      pkt_tbl[6]  = '{8'd7, MY_MAC,      16'd77, 1'b1, DEST_CPU};
      pkt_tbl[7]  = '{8'd3, MY_MAC,      16'd77, 1'b0, DEST_CPU};
      pkt_tbl[8]  = '{8'd2, FOREIGN_MAC, 16'd9,  1'b0, DEST_DROP};
      pkt_tbl[9]  = '{8'd8, MY_MAC,      PORT0,  1'b0, DEST_VITA};
      pkt_tbl[10] = '{8'd1, MY_MAC,      16'd22, 1'b0, DEST_CPU};
      pkt_tbl[11] = '{8'd1, MY_MAC,      PORT1,  1'b1, DEST_VITA};

      // Two passes over the receive table and both transmit streams
      total = 0;
      foreach (pkt_tbl[k])
         total += 2 * int'(pkt_tbl[k].len);
      foreach (tx_len[k])
         total += 4 * tx_len[k];
      limit = 20 * total + 500;

      repeat (8) @(posedge reg_clk);
      #1;
      reset = 1'b0;

      for (int k = 0; k < 4; k++)
         reg_read(reg_name[k], reg_addr[k], reg_dflt[k]);
      rd.req  = 1'b1;
      rd.addr = 14'h0008;
      repeat (2) begin
         @(posedge reg_clk);
         #1;
         rd.req = 1'b0;
         if (rd_resp)
            stop_run("Read of unmapped address 0x0008 returned a response");
      end
      for (int k = 0; k < 4; k++)
         reg_write(reg_addr[k], reg_new[k]);
      for (int k = 0; k < 4; k++)
         reg_read(reg_name[k], reg_addr[k], reg_back[k]);

      for (int pass = 0; pass < 2; pass++) begin
         bp_on = (pass == 1);
         fork
            for (int n = 0; n < NPKT; n++)
               send_rx_pkt(n);
            send_tx_pkts(1'b0);
            send_tx_pkts(1'b1);
         join
      end

      for (int w = 0; w < 200 && count_pending() != 0; w++)
         @(posedge reg_clk);
      // Quiet time to catch stray beats from dropped packets
      repeat (20) @(posedge reg_clk);

      if (count_pending() != 0 || tx_seen != tx_sent) begin
         $display("%0t: Missing packets, %0d VITA, %0d CPU, %0d transmit beats never arrived",
                  $time, vita_q.size(), cpu_q.size(), txv_q.size() + txc_q.size());
         $display("TEST FAILED");
         $fatal(1, "Expected packets did not arrive");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

//--- eth_switch.f
+incdir+include
design/eth_switch_pkg.sv
design/eth_switch_regs.sv
design/eth_pkt_gate.sv
design/eth_dispatch.sv
design/eth_tx_arbiter.sv
design/eth_switch.sv
dv/eth_switch_tb.sv

//--- include/eth_switch_defines.svh
// Register map, reset defaults and buffer sizing for the Ethernet switch
// Offsets are byte addresses on a 14-bit register bus, one 32-bit word each

`ifndef ETH_SWITCH_DEFINES_SVH
`define ETH_SWITCH_DEFINES_SVH

// Register bus address width
`define ETH_REG_AWIDTH       14

// Register byte offsets
`define ETH_REG_MAC_LSB      14'h0000
`define ETH_REG_MAC_MSB      14'h0004
`define ETH_REG_IP           14'h1000
`define ETH_REG_UDP          14'h1004

// Reset values: MAC 00:80:2f:16:c5:2f, IP 192.168.10.2, ports 49154/49153
`define ETH_DEFAULT_MAC      48'h00802f16c52f
`define ETH_DEFAULT_IP       32'hc0a80a02
`define ETH_DEFAULT_UDP      {16'd49154, 16'd49153}

// Packet gate holds 2**N beats, must cover the longest packet
`define ETH_GATE_DEPTH_LOG2  6

`endif

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module eth_switch_tb \
   -f eth_switch.f -o eth_switch_sim

./obj_dir/eth_switch_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "Simulation reported a failure, see sim.log"
   exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
   echo "Simulation ended without a pass result, see sim.log"
   exit 1
fi
